// File: project.f
+incdir+design
design/vex_pkg.sv
design/operand_select.sv
design/vector_lane.sv
design/iota_unit.sv
design/vex_execute_stage.sv
test/vex_execute_stage_tb.sv

// File: Makefile
# Verilator build and run for the vector execute stage

VERILATOR ?= verilator
TOP       ?= vex_execute_stage_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TESTS PASSED

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) design/vex_defines.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the exit status follows the pass message in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/vex_execute_stage_tb.sv
`timescale 1ns/100ps

`include "vex_defines.svh"

module vex_execute_stage_tb;

  localparam int MAX_ROWS    = 64;
  localparam int HALF_PERIOD = 20;
  localparam int DRIVE_DELAY = 2;

  logic                     CLK;
  logic                     nRST;
  logic                     stall;
  logic                     flush;
  vex_pkg::decode_execute_t de;
  vex_pkg::execute_memory_t em;
  logic                     rd_wen;
  logic [4:0]               rd_sel;
  logic [`VEX_XLEN-1:0]     rd_data;

  // one entry per row of the table
  string                    row_name   [MAX_ROWS];
  vex_pkg::decode_execute_t row_de     [MAX_ROWS];
  logic                     row_stall  [MAX_ROWS];
  logic                     row_flush  [MAX_ROWS];
  vex_pkg::execute_memory_t row_em     [MAX_ROWS];
  logic                     row_rd_wen [MAX_ROWS];
  logic [`VEX_XLEN-1:0]     row_rd     [MAX_ROWS];
  int                       num_rows;

  integer                   seed;
  int                       cycles = 0;
  int                       cycle_limit = 1000;
  int                       pass_count;
  int                       fail_count;
  int                       row_errors;
  vex_pkg::execute_memory_t last_em;

  vex_execute_stage dut_i (
    .CLK     (CLK),
    .nRST    (nRST),
    .stall   (stall),
    .flush   (flush),
    .de      (de),
    .em      (em),
    .rd_wen  (rd_wen),
    .rd_sel  (rd_sel),
    .rd_data (rd_data)
  );

  initial begin
    CLK = 1'b0;
    forever #HALF_PERIOD CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the table never finished", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // operand source as decode defines it
  function automatic logic [`VEX_XLEN-1:0] src_value(input vex_pkg::operand_src_e src,
      input logic [`VEX_XLEN-1:0] vec, input logic [`VEX_XLEN-1:0] imm,
      input logic [`VEX_XLEN-1:0] xreg);
    if (src == vex_pkg::V) return vec;
    else if (src == vex_pkg::I) return imm;
    else if (src == vex_pkg::X) return xreg;
    return '0;
  endfunction

  // b is the vs2 side, a the vs1/rs1/imm side
  function automatic logic [`VEX_XLEN-1:0] alu_expect(input vex_pkg::alu_op_e op,
      input logic [`VEX_XLEN-1:0] a, input logic [`VEX_XLEN-1:0] b);
    logic signed [`VEX_XLEN-1:0] sa;
    logic signed [`VEX_XLEN-1:0] sb;
    sa = a;
    sb = b;
    case (op)
      vex_pkg::ADD: return b + a;
      vex_pkg::SUB: return b - a;
      vex_pkg::AND: return b & a;
      vex_pkg::OR:  return b | a;
      vex_pkg::XOR: return b ^ a;
      vex_pkg::MIN: return (sb < sa) ? b : a;
      vex_pkg::MAX: return (sb > sa) ? b : a;
      default:      return b << a[4:0];
    endcase
  endfunction

  // set mask bits below idx and below vl
  function automatic logic [`VEX_XLEN-1:0] mask_prefix(
      input logic [2*`VEX_XLEN-1:0] mask, input int idx, input int vl);
    logic [`VEX_XLEN-1:0] total;
    total = '0;
    for (int i = 0; i < idx && i < vl; i++) begin
      if (mask[i]) total = total + 32'd1;
    end
    return total;
  endfunction

  function automatic vex_pkg::execute_memory_t pass_fields(input vex_pkg::decode_execute_t d);
    vex_pkg::execute_memory_t e;
    e             = '0;
    e.load        = d.load;
    e.store       = d.store;
    e.storedata0  = d.storedata0;
    e.storedata1  = d.storedata1;
    e.wen0        = d.wen0;
    e.wen1        = d.wen1;
    e.woffset0    = d.woffset0;
    e.woffset1    = d.woffset1;
    e.config_type = d.config_type;
    e.vl          = d.vl;
    e.vtype       = d.vtype;
    return e;
  endfunction

  // random data fields, plain ALU add otherwise
  task automatic random_beat(output vex_pkg::decode_execute_t d);
    logic [`VEX_XLEN-1:0] w;
    d            = '0;
    d.xs1        = $random(seed);
    d.xs2        = $random(seed);
    d.imm        = $random(seed);
    d.vs1_lane0  = $random(seed);
    d.vs1_lane1  = $random(seed);
    d.vs2_lane0  = $random(seed);
    d.vs2_lane1  = $random(seed);
    d.storedata0 = $random(seed);
    d.storedata1 = $random(seed);
    d.vtype      = $random(seed);
    w            = $random(seed);
    d.woffset0   = w[5:0];
    d.woffset1   = w[11:6];
    d.wen0       = w[12];
    d.wen1       = w[13];
    d.rd_sel     = w[18:14];
    // vl kept below 64
    d.vl         = {1'b0, w[24:19]};
  endtask

  task automatic add_row(input string name, input vex_pkg::decode_execute_t d,
      input logic st, input logic fl, input vex_pkg::execute_memory_t e,
      input logic rw, input logic [`VEX_XLEN-1:0] rdv);
    row_name[num_rows]   = name;
    row_de[num_rows]     = d;
    row_stall[num_rows]  = st;
    row_flush[num_rows]  = fl;
    row_em[num_rows]     = e;
    row_rd_wen[num_rows] = rw;
    row_rd[num_rows]     = rdv;
    last_em              = e;
    num_rows++;
  endtask

  task automatic add_alu_row(input string name, input vex_pkg::alu_op_e op,
      input vex_pkg::operand_src_e rs1, input vex_pkg::operand_src_e rs2, input logic cfg);
    vex_pkg::decode_execute_t d;
    vex_pkg::execute_memory_t e;
    logic [`VEX_XLEN-1:0]     rd_exp;
    random_beat(d);
    d.aluop       = op;
    d.rs1_type    = rs1;
    d.rs2_type    = rs2;
    d.config_type = cfg;
    d.rd_wen      = !cfg;
    e = pass_fields(d);
    e.aluresult0 = alu_expect(op, src_value(rs1, d.vs1_lane0, d.imm, d.xs1),
                              src_value(rs2, d.vs2_lane0, d.imm, d.xs2));
    e.aluresult1 = alu_expect(op, src_value(rs1, d.vs1_lane1, d.imm, d.xs1),
                              src_value(rs2, d.vs2_lane1, d.imm, d.xs2));
    // configuration beats hand vl back to the scalar file
    rd_exp = cfg ? `VEX_XLEN'(d.vl) : e.aluresult0;
    add_row(name, d, 1'b0, 1'b0, e, 1'b1, rd_exp);
  endtask

  // beat k of a load walk holds elements 2k and 2k+1
  task automatic add_walk_beat(input string name, input logic [`VEX_XLEN-1:0] base,
      input logic [`VEX_XLEN-1:0] step, input logic strided, input int k,
      input logic st, input logic fl);
    vex_pkg::decode_execute_t d;
    vex_pkg::execute_memory_t e;
    random_beat(d);
    d.fu          = vex_pkg::LSU;
    d.load        = 1'b1;
    d.stride_type = strided;
    d.stride_val  = strided ? step : d.xs2;
    d.xs1         = base;
    d.woffset0    = `VEX_IDX_W'(2 * k);
    d.woffset1    = `VEX_IDX_W'(2 * k + 1);
    e = pass_fields(d);
    e.aluresult0 = base + step * `VEX_XLEN'(2 * k);
    e.aluresult1 = base + step * `VEX_XLEN'(2 * k + 1);
    if (st) e = last_em;
    if (fl) e = '0;
    add_row(name, d, st, fl, e, 1'b0, '0);
  endtask

  task automatic build_table();
    vex_pkg::decode_execute_t d;
    vex_pkg::execute_memory_t e;
    vex_pkg::alu_op_e         opv;
    vex_pkg::operand_src_e    s1;
    vex_pkg::operand_src_e    s2;
    logic [`VEX_XLEN-1:0]     base;
    logic [`VEX_XLEN-1:0]     step;
    num_rows = 0;
    for (int op = 0; op < 8; op++) begin
      for (int src = 0; src < 3; src++) begin
        opv = vex_pkg::alu_op_e'(op);
        s1  = vex_pkg::operand_src_e'(src);
        s2  = vex_pkg::operand_src_e'((src + op) % 3);
        add_alu_row($sformatf("alu_%s_%s_%s", opv.name(), s1.name(), s2.name()),
                    opv, s1, s2, 1'b0);
      end
    end
    for (int n = 0; n < 3; n++) begin
      random_beat(d);
      d.fu = vex_pkg::IOTA;
      e = pass_fields(d);
      e.aluresult0 = mask_prefix({d.vs2_lane1, d.vs2_lane0}, d.woffset0, d.vl);
      e.aluresult1 = mask_prefix({d.vs2_lane1, d.vs2_lane0}, d.woffset1, d.vl);
      add_row($sformatf("iota_%0d", n), d, 1'b0, 1'b0, e, 1'b0, '0);
    end
    base = $random(seed);
    step = $random(seed) & 32'h0000_0ffc;
    for (int k = 0; k < 3; k++) begin
      add_walk_beat($sformatf("stride_walk_%0d", k), base, step, 1'b1, k, 1'b0, 1'b0);
    end
    base = $random(seed);
    for (int k = 0; k < 3; k++) begin
      add_walk_beat($sformatf("unit_walk_%0d", k), base, 32'd4, 1'b0, k, 1'b0, 1'b0);
    end
    random_beat(d);
    d.fu     = vex_pkg::LSU;
    d.store  = 1'b1;
    d.ls_idx = 1'b1;
    e = pass_fields(d);
    e.aluresult0 = d.xs1 + d.vs2_lane0;
    e.aluresult1 = d.xs1 + d.vs2_lane1;
    add_row("indexed_store", d, 1'b0, 1'b0, e, 1'b0, '0);
    // stall in the middle of a walk
    add_walk_beat("stall_walk_0", base, step, 1'b1, 0, 1'b0, 1'b0);
    add_walk_beat("stall_walk_hold", base, step, 1'b1, 1, 1'b1, 1'b0);
    add_walk_beat("stall_walk_1", base, step, 1'b1, 1, 1'b0, 1'b0);
    add_walk_beat("stall_walk_2", base, step, 1'b1, 2, 1'b0, 1'b0);
    // flush kills the walk, which then starts over
    add_walk_beat("flush_walk_0", base, step, 1'b1, 0, 1'b0, 1'b0);
    add_walk_beat("flush_walk_kill", base, step, 1'b1, 1, 1'b0, 1'b1);
    add_walk_beat("flush_walk_restart", base, step, 1'b1, 0, 1'b0, 1'b0);
    add_walk_beat("flush_walk_1", base, step, 1'b1, 1, 1'b0, 1'b0);
    add_alu_row("config_vl", vex_pkg::ADD, vex_pkg::V, vex_pkg::V, 1'b1);
    add_alu_row("plain_rd_sub", vex_pkg::SUB, vex_pkg::X, vex_pkg::X, 1'b0);
  endtask

  task automatic check_em(input string name, input vex_pkg::execute_memory_t exp_em,
      input vex_pkg::execute_memory_t act_em);
    if (act_em !== exp_em) begin
      $display("ERROR %s em expected %h actual %h", name, exp_em, act_em);
      row_errors++;
    end
  endtask

  task automatic check_rd(input string name, input logic [`VEX_XLEN-1:0] exp_rd,
      input logic [`VEX_XLEN-1:0] act_rd);
    if (act_rd !== exp_rd) begin
      $display("ERROR %s rd_data expected %h actual %h", name, exp_rd, act_rd);
      row_errors++;
    end
  endtask

  task automatic check_sel(input string name, input logic [4:0] exp_sel,
      input logic [4:0] act_sel);
    if (act_sel !== exp_sel) begin
      $display("ERROR %s rd_sel expected %0d actual %0d", name, exp_sel, act_sel);
      row_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp_bit, input logic act_bit);
    if (act_bit !== exp_bit) begin
      $display("ERROR %s rd_wen expected %b actual %b", name, exp_bit, act_bit);
      row_errors++;
    end
  endtask

  task automatic report_test(input string name);
    if (row_errors == 0) begin
      pass_count++;
      $display("pass %s", name);
    end else begin
      fail_count++;
      $display("fail %s", name);
    end
  endtask

  task automatic apply_row(input int r);
    de    = row_de[r];
    stall = row_stall[r];
    flush = row_flush[r];
  endtask

  initial begin
    seed       = 32'hba9c;
    nRST       = 1'b0;
    stall      = 1'b0;
    flush      = 1'b0;
    de         = '0;
    pass_count = 0;
    fail_count = 0;
    build_table();
    cycle_limit = 2 * num_rows + 20;
    repeat (3) @(posedge CLK);
    #DRIVE_DELAY;
    nRST = 1'b1;
    @(negedge CLK);
    row_errors = 0;
    check_em("reset_clear", '0, em);
    report_test("reset_clear");
    @(posedge CLK);
    #DRIVE_DELAY;
    apply_row(0);
    for (int r = 0; r < num_rows; r++) begin
      row_errors = 0;
      // write-back is combinational, sampled mid-cycle
      @(negedge CLK);
      check_flag(row_name[r], row_rd_wen[r], rd_wen);
      // destination register index passes straight through from decode
      check_sel(row_name[r], row_de[r].rd_sel, rd_sel);
      if (row_rd_wen[r]) check_rd(row_name[r], row_rd[r], rd_data);
      @(posedge CLK);
      #1;
      check_em(row_name[r], row_em[r], em);
      report_test(row_name[r]);
      #1;
      if (r + 1 < num_rows) begin
        apply_row(r + 1);
      end else begin
        de    = '0;
        stall = 1'b0;
        flush = 1'b0;
      end
    end
    $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: design/vex_execute_stage.sv
`timescale 1ns/100ps

`include "vex_defines.svh"

module vex_execute_stage (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       stall,
  input  logic                       flush,
  input  vex_pkg::decode_execute_t   de,
  output vex_pkg::execute_memory_t   em,
  output logic                       rd_wen,
  output logic [4:0]                 rd_sel,
  output logic [`VEX_XLEN-1:0]       rd_data
);

  logic [`VEX_XLEN-1:0]     op_a0, op_b0, op_a1, op_b1;
  logic [`VEX_XLEN-1:0]     iota0, iota1;
  logic [`VEX_XLEN-1:0]     base0, step0, base1, step1;
  logic [`VEX_XLEN-1:0]     addr0, addr1;
  logic [`VEX_XLEN-1:0]     res0, res1;
  logic [`VEX_XLEN-1:0]     stride_step;
  logic [`VEX_XLEN-1:0]     addr_buf;
  logic                     walk_first;
  vex_pkg::lane_ctrl_t      ctrl;
  vex_pkg::execute_memory_t em_next;

  operand_select opsel_i (
    .beat  (de),
    .op_a0 (op_a0),
    .op_b0 (op_b0),
    .op_a1 (op_a1),
    .op_b1 (op_b1)
  );

  // mask group is lane 1 vs2 over lane 0 vs2
  iota_unit iota_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .mask_bits ({de.vs2_lane1, de.vs2_lane0}),
    .vl        (de.vl),
    .idx0      (de.woffset0),
    .idx1      (de.woffset1),
    .count0    (iota0),
    .count1    (iota1)
  );

  // a walk starts on the beat holding element 0
  assign walk_first  = (de.load | de.store) & (de.woffset0 == '0);
  assign stride_step = de.stride_type ? de.stride_val : `VEX_UNIT_STRIDE;

  assign ctrl = '{fu: de.fu, aluop: de.aluop, ls_idx: de.ls_idx, first: walk_first};

  // lane 0 sits on the walk position, lane 1 is one stride further
  // indexed: both lanes are xs1 plus own vs2
  assign base0 = (de.ls_idx | walk_first) ? de.xs1 : addr_buf;
  assign step0 = de.ls_idx ? de.vs2_lane0 : '0;
  assign base1 = de.ls_idx ? de.xs1 : addr0;
  assign step1 = de.ls_idx ? de.vs2_lane1 : stride_step;

  vector_lane lane0_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .ctrl       (ctrl),
    .op_a       (op_a0),
    .op_b       (op_b0),
    .iota_count (iota0),
    .addr_base  (base0),
    .addr_step  (step0),
    .addr       (addr0),
    .result     (res0)
  );

  vector_lane lane1_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .ctrl       (ctrl),
    .op_a       (op_a1),
    .op_b       (op_b1),
    .iota_count (iota1),
    .addr_base  (base1),
    .addr_step  (step1),
    .addr       (addr1),
    .result     (res1)
  );

  // next walk position for the following beat
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      addr_buf <= '0;
    end else if (flush) begin
      addr_buf <= '0;
    end else if (!stall) begin
      addr_buf <= addr1 + stride_step;
    end
  end

  always_comb begin
    em_next             = '0;
    em_next.load        = de.load;
    em_next.store       = de.store;
    em_next.storedata0  = de.storedata0;
    em_next.storedata1  = de.storedata1;
    em_next.aluresult0  = res0;
    em_next.aluresult1  = res1;
    em_next.wen0        = de.wen0;
    em_next.wen1        = de.wen1;
    em_next.woffset0    = de.woffset0;
    em_next.woffset1    = de.woffset1;
    em_next.config_type = de.config_type;
    em_next.vl          = de.vl;
    em_next.vtype       = de.vtype;
  end

  // execute/memory register, flush wins over stall
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      em <= '0;
    end else if (flush) begin
      em <= '0;
    end else if (!stall) begin
      em <= em_next;
    end
  end

  // scalar write-back, vsetvl returns vl
  assign rd_wen  = de.rd_wen | de.config_type;
  assign rd_sel  = de.rd_sel;
  assign rd_data = de.config_type ? {{(`VEX_XLEN-`VEX_IDX_W-1){1'b0}}, de.vl} : res0;

  no_load_and_store_a : assert property (
    @(posedge CLK) disable iff (!nRST)
    !(de.load && de.store)
  );

  // flushed beat must not write the vector file downstream
  flush_kills_wen_a : assert property (
    @(posedge CLK) disable iff (!nRST)
    flush |=> (!em.wen0 && !em.wen1)
  );

endmodule

// File: design/iota_unit.sv
`timescale 1ns/100ps

`include "vex_defines.svh"

module iota_unit (
  input  logic                               CLK,
  input  logic                               nRST,
  input  logic [`VEX_LANES*`VEX_XLEN-1:0]    mask_bits,
  input  logic [`VEX_IDX_W:0]                vl,
  input  logic [`VEX_IDX_W-1:0]              idx0,
  input  logic [`VEX_IDX_W-1:0]              idx1,
  output logic [`VEX_XLEN-1:0]               count0,
  output logic [`VEX_XLEN-1:0]               count1
);

  localparam int MASK_W = `VEX_LANES * `VEX_XLEN;

  // set bits strictly below idx, tail past vl ignored
  function automatic logic [`VEX_XLEN-1:0] prefix_count(
    input logic [MASK_W-1:0]       bits,
    input logic [`VEX_IDX_W-1:0]   idx,
    input logic [`VEX_IDX_W:0]     lim
  );
    logic [`VEX_XLEN-1:0] cnt;
    cnt = '0;
    for (int i = 0; i < MASK_W; i++) begin
      if (bits[i] && (i < idx) && (i < lim)) begin
        cnt = cnt + 1'b1;
      end
    end
    return cnt;
  endfunction

  assign count0 = prefix_count(mask_bits, idx0, vl);
  assign count1 = prefix_count(mask_bits, idx1, vl);

  // one beat only carries a 64-bit mask group
  vl_in_range_a : assert property (
    @(posedge CLK) disable iff (!nRST)
    vl <= MASK_W
  );

endmodule

// File: design/vector_lane.sv
`timescale 1ns/100ps

`include "vex_defines.svh"

module vector_lane (
  input  logic                 CLK,
  input  logic                 nRST,
  input  vex_pkg::lane_ctrl_t  ctrl,
  input  logic [`VEX_XLEN-1:0] op_a,
  input  logic [`VEX_XLEN-1:0] op_b,
  input  logic [`VEX_XLEN-1:0] iota_count,
  input  logic [`VEX_XLEN-1:0] addr_base,
  input  logic [`VEX_XLEN-1:0] addr_step,
  output logic [`VEX_XLEN-1:0] addr,
  output logic [`VEX_XLEN-1:0] result
);

  logic [`VEX_XLEN-1:0] alu_val;
  logic                 b_lt_a;

  // signed compare shared by min and max
  assign b_lt_a = $signed(op_b) < $signed(op_a);

  // op_b is vs2, op_a is vs1/rs1/imm
  always_comb begin
    case (ctrl.aluop)
      vex_pkg::ADD: alu_val = op_b + op_a;
      vex_pkg::SUB: alu_val = op_b - op_a;
      vex_pkg::AND: alu_val = op_b & op_a;
      vex_pkg::OR:  alu_val = op_b | op_a;
      vex_pkg::XOR: alu_val = op_b ^ op_a;
      vex_pkg::MIN: alu_val = b_lt_a ? op_b : op_a;
      vex_pkg::MAX: alu_val = b_lt_a ? op_a : op_b;
      vex_pkg::SLL: alu_val = op_b << op_a[4:0];
      default:      alu_val = '0;
    endcase
  end

  // address adder
  assign addr = addr_base + addr_step;

  // result word by unit
  always_comb begin
    case (ctrl.fu)
      vex_pkg::ALU:  result = alu_val;
      vex_pkg::IOTA: result = iota_count;
      vex_pkg::LSU:  result = addr;
      default:       result = '0;
    endcase
  end

  // decode must never hand over the unused unit code
  fu_defined_a : assert property (
    @(posedge CLK) disable iff (!nRST)
    ctrl.fu inside {vex_pkg::ALU, vex_pkg::IOTA, vex_pkg::LSU}
  );

  // walk and indexed flags only make sense when the lane emits an address
  addr_ctrl_on_lsu_a : assert property (
    @(posedge CLK) disable iff (!nRST)
    (ctrl.first || ctrl.ls_idx) |-> (ctrl.fu == vex_pkg::LSU)
  );

endmodule

// File: design/operand_select.sv
`timescale 1ns/100ps

`include "vex_defines.svh"

module operand_select (
  input  vex_pkg::decode_execute_t beat,
  output logic [`VEX_XLEN-1:0]     op_a0,
  output logic [`VEX_XLEN-1:0]     op_b0,
  output logic [`VEX_XLEN-1:0]     op_a1,
  output logic [`VEX_XLEN-1:0]     op_b1
);

  // vector operand is per lane, immediate and scalar are broadcast
  function automatic logic [`VEX_XLEN-1:0] pick(
    input vex_pkg::operand_src_e src,
    input logic [`VEX_XLEN-1:0]  vec,
    input logic [`VEX_XLEN-1:0]  imm,
    input logic [`VEX_XLEN-1:0]  xreg
  );
    logic [`VEX_XLEN-1:0] sel;
    case (src)
      vex_pkg::V: sel = vec;
      vex_pkg::I: sel = imm;
      vex_pkg::X: sel = xreg;
      default:    sel = '0;
    endcase
    return sel;
  endfunction

  // rs1 feeds port a
  assign op_a0 = pick(beat.rs1_type, beat.vs1_lane0, beat.imm, beat.xs1);
  assign op_a1 = pick(beat.rs1_type, beat.vs1_lane1, beat.imm, beat.xs1);

  // rs2 feeds port b
  assign op_b0 = pick(beat.rs2_type, beat.vs2_lane0, beat.imm, beat.xs2);
  assign op_b1 = pick(beat.rs2_type, beat.vs2_lane1, beat.imm, beat.xs2);

endmodule

// File: design/vex_pkg.sv
`include "vex_defines.svh"

package vex_pkg;

  // operand sources
  typedef enum logic [1:0] {
    V = 2'd0,
    I = 2'd1,
    X = 2'd2
  } operand_src_e;

  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    MIN = 3'd5,
    MAX = 3'd6,
    SLL = 3'd7
  } alu_op_e;

  // functional unit, value 3 unused
  typedef enum logic [1:0] {
    ALU  = 2'd0,
    IOTA = 2'd1,
    LSU  = 2'd2
  } fu_e;

  // per-lane control
  typedef struct packed {
    fu_e     fu;
    alu_op_e aluop;
    logic    ls_idx;
    logic    first;
  } lane_ctrl_t;

  // decoded beat from decode
  typedef struct packed {
    fu_e                   fu;
    alu_op_e               aluop;
    operand_src_e          rs1_type;
    operand_src_e          rs2_type;
    logic                  load;
    logic                  store;
    logic                  ls_idx;
    logic                  stride_type;
    logic [`VEX_XLEN-1:0]  stride_val;
    logic [`VEX_XLEN-1:0]  xs1;
    logic [`VEX_XLEN-1:0]  xs2;
    logic [`VEX_XLEN-1:0]  imm;
    logic [`VEX_XLEN-1:0]  vs1_lane0;
    logic [`VEX_XLEN-1:0]  vs1_lane1;
    logic [`VEX_XLEN-1:0]  vs2_lane0;
    logic [`VEX_XLEN-1:0]  vs2_lane1;
    logic [`VEX_XLEN-1:0]  storedata0;
    logic [`VEX_XLEN-1:0]  storedata1;
    logic [`VEX_IDX_W-1:0] woffset0;
    logic [`VEX_IDX_W-1:0] woffset1;
    logic                  wen0;
    logic                  wen1;
    logic [`VEX_IDX_W:0]   vl;
    logic [`VEX_XLEN-1:0]  vtype;
    logic                  config_type;
    logic                  rd_wen;
    logic [4:0]            rd_sel;
  } decode_execute_t;

  // registered toward memory stage
  typedef struct packed {
    logic                  load;
    logic                  store;
    logic [`VEX_XLEN-1:0]  storedata0;
    logic [`VEX_XLEN-1:0]  storedata1;
    logic [`VEX_XLEN-1:0]  aluresult0;
    logic [`VEX_XLEN-1:0]  aluresult1;
    logic                  wen0;
    logic                  wen1;
    logic [`VEX_IDX_W-1:0] woffset0;
    logic [`VEX_IDX_W-1:0] woffset1;
    logic                  config_type;
    logic [`VEX_IDX_W:0]   vl;
    logic [`VEX_XLEN-1:0]  vtype;
  } execute_memory_t;

endpackage

// File: design/vex_defines.svh
`ifndef VEX_DEFINES_SVH
`define VEX_DEFINES_SVH

// element and scalar width, only SEW=32 handled
`define VEX_XLEN 32

// elements per beat
`define VEX_LANES 2

// element index inside a 64-element mask group
`define VEX_IDX_W 6

// byte step between consecutive unit-stride elements
`define VEX_UNIT_STRIDE 4

`endif
